//--- Makefile
SIM     = obj_dir/Vmasked_reduce_tb
SOURCES = $(shell cat masked_reduce_top.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): masked_reduce_top.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module masked_reduce_tb \
		-f masked_reduce_top.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

//--- masked_reduce_top.f
src/masked_reduce_pkg.sv
src/reduction_decode.sv
src/mask_random_source.sv
src/masked_barrett_if_cond.sv
src/masked_barrett_reduction.sv
src/reduction_result.sv
src/masked_reduce_top.sv
verif/masked_reduce_sva.sv
verif/masked_reduce_tb.sv

//--- src/mask_random_source.sv
`timescale 1ns/1ps

module mask_random_source
    import masked_reduce_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    zeroize,
    input  logic                    reseed_valid,
    input  logic [SEED_WIDTH-1:0]   reseed_seed,
    output mask_rnd_t               rnd
);

    localparam int RND_BITS = $bits(mask_rnd_t);
    localparam logic [SEED_WIDTH-1:0] RESET_SEED = 32'hACE1_2468;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [SEED_WIDTH-1:0] TAPS = 32'h8020_0003;

    logic [SEED_WIDTH-1:0] lfsr_q;
    logic [SEED_WIDTH-1:0] lfsr_step;
    logic [RND_BITS-1:0]   rnd_bits;

    // Run the Galois LFSR RND_BITS steps per clock
    always_comb begin
        lfsr_step = lfsr_q;
        for (int i = 0; i < RND_BITS; i++) begin
            rnd_bits[i] = lfsr_step[0];
            lfsr_step   = lfsr_step[0] ? ((lfsr_step >> 1) ^ TAPS) : (lfsr_step >> 1);
        end
    end

    assign rnd = mask_rnd_t'(rnd_bits);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= RESET_SEED;
        end else if (zeroize) begin
            lfsr_q <= RESET_SEED;
        end else if (reseed_valid) begin
            // All-zero state would lock up
            lfsr_q <= (reseed_seed == '0) ? RESET_SEED : reseed_seed;
        end else begin
            lfsr_q <= lfsr_step;
        end
    end

endmodule

//--- src/masked_barrett_if_cond.sv
`timescale 1ns/1ps

module masked_barrett_if_cond
    import masked_reduce_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            zeroize,
    input  logic [1:0][MLKEM_Q_WIDTH+1:0]   c_rolled,
    input  mask_rnd_t                       rnd,
    output logic [1:0][MLKEM_Q_WIDTH-1:0]   arith_q
);

    localparam logic [MLKEM_Q_WIDTH-1:0] TWO_Q = MLKEM_Q_WIDTH'(2 * MLKEM_Q);

    logic [1:0][MLKEM_Q_WIDTH+1:0] bm;
    logic [1:0][MLKEM_Q_WIDTH+1:0] bmask;
    logic [MLKEM_Q_WIDTH+1:0]      sum_rolled;
    logic                          sign_mask;
    logic [1:0]                    sb;
    logic [1:0]                    b;
    logic [MLKEM_Q_WIDTH-1:0]      q_b0;
    logic [MLKEM_Q_WIDTH-1:0]      q_b1;
    logic [MLKEM_Q_WIDTH-1:0]      q_cross;
    logic                          rst_seen;

    // ------------------------------------------------------------------------
    // Stage A: arithmetic refresh, then Boolean masks per share
    // Stage B: bit 12 of the share sum as a Boolean pair
    // Stage C: Boolean bit to an arithmetic sharing of q or 0
    // ------------------------------------------------------------------------
    always_comb begin
        sum_rolled = (bm[0] ^ bmask[0]) + (bm[1] ^ bmask[1]);
        sign_mask  = bmask[0][MLKEM_Q_WIDTH] ^ bmask[1][MLKEM_Q_WIDTH];
        b[0] = sb[0] ^ rnd.rnd_1bit;
        b[1] = sb[1] ^ rnd.rnd_1bit;
        q_b0    = b[0] ? MLKEM_Q : '0;
        q_b1    = b[1] ? MLKEM_Q : '0;
        // q*(b0 ^ b1) = q*b0 + q*b1 - 2q*b0*b1
        q_cross = (b[0] & b[1]) ? TWO_Q : '0;
    end

    // Flags stage contents as flushed after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_seen <= 1'b0;
        end else begin
            rst_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize || !rst_seen) begin
            bm      <= '0;
            bmask   <= '0;
            sb      <= '0;
            arith_q <= '0;
        end else begin
            bm[0]      <= (c_rolled[0] + rnd.rnd_14bit) ^ rnd.rnd_bool0;
            bm[1]      <= (c_rolled[1] - rnd.rnd_14bit) ^ rnd.rnd_bool1;
            bmask[0]   <= rnd.rnd_bool0;
            bmask[1]   <= rnd.rnd_bool1;
            sb[0]      <= sum_rolled[MLKEM_Q_WIDTH] ^ sign_mask;
            sb[1]      <= sign_mask;
            arith_q[0] <= q_b0 - rnd.rnd_12bit;
            arith_q[1] <= q_b1 - q_cross + rnd.rnd_12bit;
        end
    end

endmodule

//--- src/masked_barrett_reduction.sv
`timescale 1ns/1ps

module masked_barrett_reduction
    import masked_reduce_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            zeroize,
    input  logic            issue_valid,
    input  reduce_issue_t   issue,
    input  mask_rnd_t       rnd,
    output logic            done_valid,
    output reduce_result_t  done_result
);

    localparam int LATENCY = 6;
    localparam int PROD_WIDTH = SHARE_WIDTH + 13;
    // floor(2^24 / q)
    localparam logic [12:0] MU = 13'd5039;
    localparam logic [PROD_WIDTH-1:0] MU_SHIFTED = PROD_WIDTH'(MU) << SHARE_WIDTH;
    // Moves q onto bit 12 so that bit flags c >= q
    localparam logic [13:0] ROLLER = 14'((1 << MLKEM_Q_WIDTH) - MLKEM_Q);

    // x * mu with the constant written as shifts
    function automatic logic [PROD_WIDTH-1:0] mul_mu(input logic [SHARE_WIDTH-1:0] v);
        logic [PROD_WIDTH-1:0] e;
        e = PROD_WIDTH'(v);
        return (e << 12) + (e << 9) + (e << 8) + (e << 7) + (e << 5) + (e << 3)
             + (e << 2) + (e << 1) + e;
    endfunction

    logic [SHARE_WIDTH:0]       x_sum;
    logic                       carry_x;
    logic [1:0][PROD_WIDTH-1:0] tmp;
    logic [SHARE_WIDTH:0]       tmp_low_sum;
    logic                       carry_tmp;
    logic [1:0][12:0]           t_next;
    logic [1:0][12:0]           t;
    logic [1:0][12:0]           x_lo;
    logic [1:0][12:0]           c_next;
    logic [1:0][12:0]           c;
    logic [13:0]                c_sum;
    logic                       carry_c;
    logic [1:0][13:0]           c_rolled;
    logic [1:0][12:0]           c_dly [3];
    logic [1:0][MLKEM_Q_WIDTH-1:0] arith_q;
    logic [1:0][MLKEM_Q_WIDTH-1:0] y_int;
    logic [MLKEM_Q_WIDTH:0]     y_sum;
    logic                       carry_y;
    logic [1:0][SHARE_WIDTH-1:0] y;
    logic [LATENCY-1:0]         valid_pipe;
    logic [TAG_WIDTH-1:0]       tag_pipe [LATENCY];

    // ------------------------------------------------------------------------
    // Stage 1: masked quotient estimate t
    // ------------------------------------------------------------------------
    always_comb begin
        x_sum   = {1'b0, issue.shares.share0} + {1'b0, issue.shares.share1};
        carry_x = x_sum[SHARE_WIDTH];
        // Share sum wrapped past 2^24, take mu * 2^24 back out of share 0
        tmp[0] = mul_mu(issue.shares.share0) - (carry_x ? MU_SHIFTED : '0);
        tmp[1] = mul_mu(issue.shares.share1);
        tmp_low_sum = {1'b0, tmp[0][SHARE_WIDTH-1:0]} + {1'b0, tmp[1][SHARE_WIDTH-1:0]};
        carry_tmp   = tmp_low_sum[SHARE_WIDTH];
        t_next[0] = tmp[0][PROD_WIDTH-1:SHARE_WIDTH] + 13'(carry_tmp);
        t_next[1] = tmp[1][PROD_WIDTH-1:SHARE_WIDTH];
    end

    // ------------------------------------------------------------------------
    // Stage 2: c = x - q*t on the shares, modulo 2^13
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            c_next[i] = x_lo[i] - ((t[i] << 11) + (t[i] << 10) + (t[i] << 8) + t[i]);
        end
        c_sum   = {1'b0, c[0]} + {1'b0, c[1]};
        carry_c = c_sum[13];
        c_rolled[0] = {1'b0, c[0]} + ROLLER - {carry_c, 13'b0};
        c_rolled[1] = {1'b0, c[1]};
    end

    // Stages 3 to 5
    masked_barrett_if_cond masked_barrett_if_cond_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .zeroize  (zeroize),
        .c_rolled (c_rolled),
        .rnd      (rnd),
        .arith_q  (arith_q)
    );

    // ------------------------------------------------------------------------
    // Stage 6: y = c - q*b and remask
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            y_int[i] = c_dly[2][i][MLKEM_Q_WIDTH-1:0] - arith_q[i];
        end
        y_sum   = {1'b0, y_int[0]} + {1'b0, y_int[1]};
        carry_y = y_sum[MLKEM_Q_WIDTH];
    end

    always_ff @(posedge clk) begin
        if (zeroize) begin
            t     <= '0;
            x_lo  <= '0;
            c     <= '0;
            c_dly <= '{default: '0};
            y     <= '0;
        end else begin
            t        <= t_next;
            x_lo[0]  <= issue.shares.share0[12:0];
            x_lo[1]  <= issue.shares.share1[12:0];
            c        <= c_next;
            c_dly[0] <= c;
            c_dly[1] <= c_dly[0];
            c_dly[2] <= c_dly[1];
            y[0] <= SHARE_WIDTH'(y_int[0]) - rnd.rnd_share
                  - (SHARE_WIDTH'(carry_y) << MLKEM_Q_WIDTH);
            y[1] <= SHARE_WIDTH'(y_int[1]) + rnd.rnd_share;
        end
    end

    // Valid and tag follow the data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else if (zeroize) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[LATENCY-2:0], issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        tag_pipe[0] <= issue.tag;
        for (int i = 1; i < LATENCY; i++) begin
            tag_pipe[i] <= tag_pipe[i-1];
        end
    end

    assign done_valid = valid_pipe[LATENCY-1];

    always_comb begin
        done_result.tag           = tag_pipe[LATENCY-1];
        done_result.shares.share0 = y[0];
        done_result.shares.share1 = y[1];
    end

endmodule

//--- src/masked_reduce_pkg.sv
package masked_reduce_pkg;

    // Coefficient arithmetic
    parameter int MLKEM_Q_WIDTH = 12;
    parameter logic [MLKEM_Q_WIDTH-1:0] MLKEM_Q = 12'd3329;
    parameter int SHARE_WIDTH = 2 * MLKEM_Q_WIDTH;

    // Command fields
    parameter int TAG_WIDTH = 4;
    parameter int SEED_WIDTH = 32;
    parameter int SEED_PAD_WIDTH = 2 * SHARE_WIDTH - SEED_WIDTH;

    typedef enum logic {
        OP_REDUCE = 1'b0,
        OP_RESEED = 1'b1
    } opcode_t;

    typedef struct packed {
        logic [SHARE_WIDTH-1:0] share0;
        logic [SHARE_WIDTH-1:0] share1;
    } share_pair_t;

    typedef struct packed {
        logic [SEED_PAD_WIDTH-1:0] pad;
        logic [SEED_WIDTH-1:0]     seed;
    } seed_word_t;

    // Same payload bits, read by opcode
    typedef union packed {
        share_pair_t shares;
        seed_word_t  seed_word;
    } cmd_payload_u;

    typedef struct packed {
        opcode_t                opcode;
        logic [TAG_WIDTH-1:0]   tag;
        cmd_payload_u           payload;
    } reduce_cmd_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]   tag;
        share_pair_t            shares;
    } reduce_issue_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]   tag;
        share_pair_t            shares;
    } reduce_result_t;

    // Fresh randomness consumed by one reduction step
    typedef struct packed {
        logic [MLKEM_Q_WIDTH-1:0]   rnd_12bit;
        logic [MLKEM_Q_WIDTH+1:0]   rnd_14bit;
        logic [SHARE_WIDTH-1:0]     rnd_share;
        logic [MLKEM_Q_WIDTH+1:0]   rnd_bool0;
        logic [MLKEM_Q_WIDTH+1:0]   rnd_bool1;
        logic                       rnd_1bit;
    } mask_rnd_t;

endpackage

//--- src/masked_reduce_top.sv
`timescale 1ns/1ps

module masked_reduce_top
    import masked_reduce_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            zeroize,
    input  logic            in_valid,
    input  reduce_cmd_t     in_cmd,
    output logic            in_credit,
    output logic            out_valid,
    output reduce_result_t  out_result,
    input  logic            out_credit
);

    logic                   issue_valid;
    reduce_issue_t          issue;
    logic                   reseed_valid;
    logic [SEED_WIDTH-1:0]  reseed_seed;
    logic                   reseed_done;
    mask_rnd_t              rnd;
    logic                   done_valid;
    reduce_result_t         done_result;

    reduction_decode reduction_decode_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .zeroize      (zeroize),
        .in_valid     (in_valid),
        .in_cmd       (in_cmd),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .reseed_valid (reseed_valid),
        .reseed_seed  (reseed_seed),
        .reseed_done  (reseed_done)
    );

    mask_random_source mask_random_source_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .zeroize      (zeroize),
        .reseed_valid (reseed_valid),
        .reseed_seed  (reseed_seed),
        .rnd          (rnd)
    );

    masked_barrett_reduction masked_barrett_reduction_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .zeroize      (zeroize),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .rnd          (rnd),
        .done_valid   (done_valid),
        .done_result  (done_result)
    );

    reduction_result #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) reduction_result_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .zeroize      (zeroize),
        .done_valid   (done_valid),
        .done_result  (done_result),
        .reseed_done  (reseed_done),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .in_credit    (in_credit)
    );

endmodule

//--- src/reduction_decode.sv
`timescale 1ns/1ps

module reduction_decode
    import masked_reduce_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    zeroize,
    input  logic                    in_valid,
    input  reduce_cmd_t             in_cmd,
    output logic                    issue_valid,
    output reduce_issue_t           issue,
    output logic                    reseed_valid,
    output logic [SEED_WIDTH-1:0]   reseed_seed,
    output logic                    reseed_done
);

    logic is_reduce;
    logic is_reseed;

    assign is_reduce = in_valid && (in_cmd.opcode == OP_REDUCE);
    assign is_reseed = in_valid && (in_cmd.opcode == OP_RESEED);

    // Command strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid  <= 1'b0;
            reseed_valid <= 1'b0;
            reseed_done  <= 1'b0;
        end else if (zeroize) begin
            issue_valid  <= 1'b0;
            reseed_valid <= 1'b0;
            reseed_done  <= 1'b0;
        end else begin
            issue_valid  <= is_reduce;
            reseed_valid <= is_reseed;
            reseed_done  <= reseed_valid;
        end
    end

    // Payload decoded as shares or as a seed
    always_ff @(posedge clk) begin
        if (is_reduce) begin
            issue.tag    <= in_cmd.tag;
            issue.shares <= in_cmd.payload.shares;
        end
        if (is_reseed) begin
            reseed_seed <= in_cmd.payload.seed_word.seed;
        end
    end

endmodule

//--- src/reduction_result.sv
`timescale 1ns/1ps

module reduction_result
    import masked_reduce_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            zeroize,
    input  logic            done_valid,
    input  reduce_result_t  done_result,
    input  logic            reseed_done,
    input  logic            out_credit,
    output logic            out_valid,
    output reduce_result_t  out_result,
    output logic            in_credit
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int CREDIT_W = 16;

    reduce_result_t        fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      fifo_count;
    logic                  fifo_empty;
    logic                  wr_en;
    logic                  pop;
    logic [CREDIT_W-1:0]   out_credit_cnt;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign fifo_empty = (fifo_count == '0);
    // Input credits reserve a slot for every result in flight
    assign wr_en      = done_valid;
    assign out_valid  = !fifo_empty && (out_credit_cnt != '0);
    assign pop        = out_valid;
    assign out_result = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            fifo_mem[wr_ptr] <= done_result;
        end
    end

    // ------------------------------------------------------------------------
    // Pointers, occupancy and credits
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            fifo_count     <= '0;
            out_credit_cnt <= '0;
            in_credit      <= 1'b0;
        end else if (zeroize) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            fifo_count     <= '0;
            out_credit_cnt <= '0;
            in_credit      <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            fifo_count     <= fifo_count + CNT_W'(wr_en) - CNT_W'(pop);
            out_credit_cnt <= out_credit_cnt + CREDIT_W'(out_credit) - CREDIT_W'(pop);
            // Slot freed or reseed retired
            in_credit      <= pop | reseed_done;
        end
    end

endmodule

//--- verif/masked_reduce_sva.sv
`timescale 1ns/1ps

module masked_reduce_sva #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    zeroize,
    input  logic    issue_valid,
    input  logic    done_valid,
    input  logic    reseed_done,
    input  logic    out_valid,
    input  logic    out_credit
);

    localparam int LATENCY = 6;

    int credit_cnt;
    int fifo_cnt;

    // Shadow counts of output credits and FIFO occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= 0;
            fifo_cnt   <= 0;
        end else if (zeroize) begin
            credit_cnt <= 0;
            fifo_cnt   <= 0;
        end else begin
            credit_cnt <= credit_cnt + int'(out_credit) - int'(out_valid);
            fifo_cnt   <= fifo_cnt + int'(done_valid) - int'(out_valid);
        end
    end

    // ------------------------------------------------------------------------
    // Output channel and FIFO
    // ------------------------------------------------------------------------
    valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n || zeroize)
        out_valid |-> (credit_cnt > 0))
        else $error("out_valid asserted with no output credit");

    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n || zeroize)
        done_valid |-> (fifo_cnt < FIFO_DEPTH))
        else $error("FIFO written while full");

    // ------------------------------------------------------------------------
    // Pipeline and credit return
    // ------------------------------------------------------------------------
    issue_to_done: assert property (@(posedge clk) disable iff (!rst_n || zeroize)
        issue_valid |-> ##LATENCY done_valid)
        else $error("done_valid missing six cycles after issue");

    done_from_issue: assert property (@(posedge clk) disable iff (!rst_n || zeroize)
        done_valid |-> $past(issue_valid, LATENCY))
        else $error("done_valid without an issue six cycles earlier");

    pop_reseed_apart: assert property (@(posedge clk) disable iff (!rst_n || zeroize)
        !(out_valid && reseed_done))
        else $error("pop and reseed_done in the same cycle");

endmodule

bind masked_reduce_top masked_reduce_sva #(
    .FIFO_DEPTH (FIFO_DEPTH)
) masked_reduce_sva_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .zeroize     (zeroize),
    .issue_valid (issue_valid),
    .done_valid  (done_valid),
    .reseed_done (reseed_done),
    .out_valid   (out_valid),
    .out_credit  (out_credit)
);

//--- verif/masked_reduce_tb.sv
`timescale 1ns/1ps

module masked_reduce_tb
    import masked_reduce_pkg::*;
();

    localparam int FIFO_DEPTH = 8;
    localparam int WAIT_LIMIT = 400;
    localparam int NUM_RANDOM = 40;
    localparam int GRANT_LIMIT = 4;
    localparam logic [31:0] LFSR_SEED = 32'd67274;

    typedef struct packed {
        opcode_t                    op;
        logic [TAG_WIDTH-1:0]       tag;
        logic [SHARE_WIDTH-1:0]     s0;
        logic [SHARE_WIDTH-1:0]     s1;
        logic [MLKEM_Q_WIDTH-1:0]   exp_val;
    } vector_t;

    // Reseed entries carry the seed as {s0[7:0], s1}
    // Expected value is ((s0 + s1) mod 2^24) mod 3329
    vector_t vectors [14] = '{
        '{OP_RESEED, 4'h0, 24'h000013, 24'h57A9C1, 12'd0},
        '{OP_REDUCE, 4'h1, 24'd0,      24'd0,      12'd0},
        '{OP_REDUCE, 4'h2, 24'd3328,   24'd0,      12'd3328},
        '{OP_REDUCE, 4'h3, 24'd3329,   24'd0,      12'd0},
        '{OP_REDUCE, 4'h4, 24'd3000,   24'd329,    12'd0},
        '{OP_REDUCE, 4'h5, 24'hFFFFFF, 24'd0,      12'd2384},
        '{OP_REDUCE, 4'h6, 24'h7FFFFF, 24'h800000, 12'd2384},
        '{OP_REDUCE, 4'h7, 24'hFFFFFF, 24'h000001, 12'd0},
        '{OP_REDUCE, 4'h8, 24'hFFF000, 24'h002000, 12'd767},
        '{OP_REDUCE, 4'h9, 24'd1,      24'd6656,   12'd3328},
        '{OP_REDUCE, 4'hA, 24'd6000,   24'd658,    12'd0},
        '{OP_REDUCE, 4'hB, 24'h123456, 24'h654321, 12'd2888},
        '{OP_REDUCE, 4'hC, 24'hABCDEF, 24'h876543, 12'd3139},
        '{OP_REDUCE, 4'hD, 24'hFFFFFF, 24'd3329,   12'd3328}
    };

    logic           clk;
    logic           rst_n;
    logic           zeroize;
    logic           in_valid;
    reduce_cmd_t    in_cmd;
    logic           in_credit;
    logic           out_valid;
    reduce_result_t out_result;
    logic           out_credit;

    logic           grant_en;
    logic [31:0]    lfsr_state;
    string          test_name;
    int             in_credits;
    int             granted;
    int             credit_pulses;
    int             received;
    int             cycle_count;
    int             sent_cycle;
    int             out_cycle;
    reduce_result_t exp_queue [$];
    reduce_result_t last_result;

    masked_reduce_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) masked_reduce_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .zeroize    (zeroize),
        .in_valid   (in_valid),
        .in_cmd     (in_cmd),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Reference model and random source
    // ------------------------------------------------------------------------
    function automatic logic [MLKEM_Q_WIDTH-1:0] expected_value(
        input logic [SHARE_WIDTH-1:0] s0,
        input logic [SHARE_WIDTH-1:0] s1
    );
        logic [SHARE_WIDTH-1:0] sum;
        sum = s0 + s1;
        return MLKEM_Q_WIDTH'(sum % SHARE_WIDTH'(MLKEM_Q));
    endfunction

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [SHARE_WIDTH-1:0] lfsr_bits(input int n);
        logic [SHARE_WIDTH-1:0] v;
        logic                   fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[SHARE_WIDTH-2:0], fb};
        end
        return v;
    endfunction

    function automatic vector_t random_vector(input logic [TAG_WIDTH-1:0] tag);
        vector_t v;
        v.op      = OP_REDUCE;
        v.tag     = tag;
        v.s0      = lfsr_bits(SHARE_WIDTH);
        v.s1      = lfsr_bits(SHARE_WIDTH);
        v.exp_val = expected_value(v.s0, v.s1);
        return v;
    endfunction

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_result(input reduce_result_t exp, input reduce_result_t act);
        logic [SHARE_WIDTH-1:0] sum;
        sum = act.shares.share0 + act.shares.share1;
        if (act.tag !== exp.tag) begin
            report_failure($sformatf("MISMATCH %s: tag expected %0h, actual %0h",
                test_name, exp.tag, act.tag));
        end else if (sum !== exp.shares.share0) begin
            report_failure($sformatf("MISMATCH %s: share sum for tag %0h expected %0d, actual %0d",
                test_name, exp.tag, exp.shares.share0, sum));
        end
    endtask

    task automatic check_credits(input string what, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("MISMATCH %s: %s expected %0d, actual %0d",
                test_name, what, exp, act));
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("MISMATCH %s: %s expected %0d, actual %0d",
                test_name, what, exp, act));
        end
    endtask

    // Falling edge: sample outputs, then drive the downstream credit
    task automatic next_cycle();
        reduce_result_t exp;
        @(negedge clk);
        cycle_count++;
        if (in_credit) begin
            in_credits++;
            credit_pulses++;
            if (in_credits > FIFO_DEPTH) begin
                report_failure("input credit returned with no command outstanding");
            end
        end
        if (out_valid) begin
            if (exp_queue.size() == 0) begin
                report_failure("result appeared with no command outstanding");
            end else begin
                exp = exp_queue.pop_front();
                check_result(exp, out_result);
                last_result = out_result;
                received++;
                granted--;
                out_cycle = cycle_count;
            end
        end
        out_credit = grant_en && (granted < GRANT_LIMIT);
        if (out_credit) begin
            granted++;
        end
    endtask

    task automatic send_cmd(input vector_t v);
        reduce_result_t exp;
        int             waited;
        waited = 0;
        while (in_credits == 0) begin
            if (waited >= WAIT_LIMIT) begin
                report_failure("timeout waiting for an input credit");
            end
            next_cycle();
            waited++;
        end
        in_valid      = 1'b1;
        in_cmd.opcode = v.op;
        in_cmd.tag    = v.tag;
        if (v.op == OP_REDUCE) begin
            in_cmd.payload.shares.share0 = v.s0;
            in_cmd.payload.shares.share1 = v.s1;
            exp.tag           = v.tag;
            exp.shares.share0 = SHARE_WIDTH'(v.exp_val);
            exp.shares.share1 = '0;
            exp_queue.push_back(exp);
        end else begin
            in_cmd.payload.seed_word.pad  = '0;
            in_cmd.payload.seed_word.seed = {v.s0[7:0], v.s1};
        end
        in_credits--;
        next_cycle();
        sent_cycle = cycle_count;
        in_valid   = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_queue.size() != 0 || in_credits != FIFO_DEPTH) begin
            if (waited >= WAIT_LIMIT) begin
                report_failure("timeout waiting for results and input credits to return");
            end
            next_cycle();
            waited++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        vector_t        reseed_cmd;
        reduce_result_t before_reseed;
        int             received_before;
        int             waited;
        rst_n         = 1'b0;
        zeroize       = 1'b0;
        in_valid      = 1'b0;
        in_cmd        = '0;
        out_credit    = 1'b0;
        grant_en      = 1'b0;
        lfsr_state    = LFSR_SEED;
        test_name     = "reset";
        in_credits    = FIFO_DEPTH;
        granted       = 0;
        credit_pulses = 0;
        received      = 0;
        cycle_count   = 0;
        sent_cycle    = 0;
        out_cycle     = 0;
        last_result   = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Output credits withheld, results pile up in the FIFO
        test_name = "backpressure";
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            send_cmd(random_vector(TAG_WIDTH'(i)));
        end
        repeat (20) next_cycle();
        check_count("results without out_credit", 0, received);
        check_credits("in_credit pulses without out_credit", 0, credit_pulses);
        grant_en = 1'b1;
        wait_idle();

        test_name = "vector table";
        foreach (vectors[i]) begin
            send_cmd(vectors[i]);
        end
        wait_idle();

        // Same input around a reseed
        test_name = "reseed";
        send_cmd(vectors[11]);
        wait_idle();
        before_reseed   = last_result;
        reseed_cmd      = vectors[0];
        reseed_cmd.s0   = 24'h0000A5;
        reseed_cmd.s1   = 24'h3C5A69;
        send_cmd(reseed_cmd);
        wait_idle();
        send_cmd(vectors[11]);
        wait_idle();
        if (last_result.shares.share0 == before_reseed.shares.share0) begin
            report_failure("output shares did not change after reseed");
        end

        test_name = "latency";
        received_before = received;
        send_cmd(vectors[12]);
        waited = 0;
        while (received == received_before) begin
            if (waited >= WAIT_LIMIT) begin
                report_failure("timeout waiting for out_valid");
            end
            next_cycle();
            waited++;
        end
        check_count("cycles from accept to out_valid", 7, out_cycle - sent_cycle);
        wait_idle();

        test_name = "random back-to-back";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            send_cmd(random_vector(TAG_WIDTH'(i)));
        end
        wait_idle();

        test_name = "zeroize";
        grant_en = 1'b0;
        next_cycle();
        zeroize = 1'b1;
        next_cycle();
        next_cycle();
        zeroize    = 1'b0;
        in_credits = FIFO_DEPTH;
        granted    = 0;
        // Output credits granted earlier are gone, so this result has to wait
        received_before = received;
        send_cmd(random_vector(TAG_WIDTH'(2)));
        repeat (20) next_cycle();
        check_count("results after zeroize without out_credit", received_before, received);
        grant_en = 1'b1;
        for (int i = 0; i < 10; i++) begin
            send_cmd(random_vector(TAG_WIDTH'(i + 3)));
        end
        wait_idle();

        $display("Test passed");
        $finish;
    end

endmodule
